// File: usiBus_settings.svh
/*
 Bus widths, slave lane count and block address map of the register bus.
 Include in every file that sizes bus signals or decodes block numbers.
*/
`ifndef USI_BUS_SETTINGS_SVH
`define USI_BUS_SETTINGS_SVH

// --------------------
// Bus widths
// --------------------
`define USI_ADRS_BIT 16
`define USI_DATA_BIT 32
// Upper address byte selects the block
`define USI_BLOCK_BIT 8

// One valid lane per slave, GPIO lane 0, PWM lane 1
`define USI_SLAVE_NUM 2

// --------------------
// Block address map
// --------------------
// Block 0 and numbers above PWM are reserved
`define GPIO_BLOCK_ID 8'h01
`define PWM_BLOCK_ID 8'h02

`endif

// File: usiPkg.sv
/*
 Shared bus types for the register bus.
 Modules refer to these by scoped names, usiPkg::busDataT and so on.
*/
`include "usiBus_settings.svh"

package usiPkg;

	// --------------------
	// Bus words
	// --------------------
	// Block number in upper byte, register offset in lower byte
	typedef logic [`USI_ADRS_BIT-1:0] busAdrsT;

	// Write and read data word
	typedef logic [`USI_DATA_BIT-1:0] busDataT;

	// One-hot read valid, bit per slave lane
	typedef logic [`USI_SLAVE_NUM-1:0] busVdT;

	// --------------------
	// Register offset
	// --------------------
	// Lower address byte, decoded inside each slave
	typedef logic [`USI_ADRS_BIT-`USI_BLOCK_BIT-1:0] regOffsetT;

endpackage

// File: UltraSimpleInterface.sv
/*
 Register bus interconnect between one master and the slave blocks.
 Master commands are registered and broadcast to every slave; the read data
 of the slave raising its valid lane is selected and registered back.
*/
`timescale 1ns/1ns
`include "usiBus_settings.svh"

module UltraSimpleInterface
(
	input  logic                                    sysClk,
	input  logic                                    rstN,
	// Master side
	input  usiPkg::busDataT                         musiWd,
	input  usiPkg::busAdrsT                         musiAdrs,
	input  logic                                    musiWCke,
	output usiPkg::busDataT                         musiRd,
	output usiPkg::busVdT                           musiVd,
	// Slave side
	output usiPkg::busDataT                         susiWd,
	output usiPkg::busAdrsT                         susiAdrs,
	output logic                                    susiWCke,
	input  usiPkg::busDataT [`USI_SLAVE_NUM-1:0]    susiRd,
	input  usiPkg::busVdT                           susiVd
);

	// Selected slave read data
	usiPkg::busDataT rdSel;

	// --------------------
	// Command broadcast
	// --------------------
	// Address and strobe go to every slave one cycle later
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			susiAdrs <= '0;
			susiWCke <= 1'b0;
		end
		else
		begin
			susiAdrs <= musiAdrs;
			susiWCke <= musiWCke;
		end
	end

	// Write data, meaningful only with susiWCke
	always_ff @(posedge sysClk)
	begin
		susiWd <= musiWd;
	end

	// --------------------
	// Read return
	// --------------------
	// Slaves decode their own block, so at most one lane is valid
	// Data of lanes without valid is masked off
	always_comb
	begin
		rdSel = '0;
		for (int i = 0; i < `USI_SLAVE_NUM; i++)
		begin
			if (susiVd[i])
			begin
				rdSel = rdSel | susiRd[i];
			end
		end
	end

	// Valid vector is control state
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			musiVd <= '0;
		end
		else
		begin
			musiVd <= susiVd;
		end
	end

	// Returned data word
	always_ff @(posedge sysClk)
	begin
		musiRd <= rdSel;
	end

endmodule

// File: GpioBlock.sv
/*
 GPIO slave on the register bus: LED edge register and LED clock divider.
 Offset 0 holds the 2-bit LED edge value, offset 1 the 16-bit divider.
 Commands are registered on entry; writes and read answers follow a cycle later.
*/
`timescale 1ns/1ns
`include "usiBus_settings.svh"

module GpioBlock
(
	input  logic            sysClk,
	input  logic            rstN,
	input  usiPkg::busDataT susiWd,
	input  usiPkg::busAdrsT susiAdrs,
	input  logic            susiWCke,
	output usiPkg::busDataT susiRd,
	output logic            susiVd,
	output logic [1:0]      ledEdge,
	output logic            ledClk
);

	localparam usiPkg::regOffsetT ledEdgeOfs = 'd0;
	localparam usiPkg::regOffsetT ledDivOfs  = 'd1;

	// Decoded command stage
	logic              blockHit;
	logic              cmdRead;
	logic              cmdWrite;
	usiPkg::regOffsetT cmdOfs;
	usiPkg::busDataT   cmdWd;
	usiPkg::busDataT   rdNext;
	// Divider state
	logic [15:0]       ledDiv;
	logic [15:0]       divCnt;

	// --------------------
	// Command decode
	// --------------------
	assign blockHit = susiAdrs[`USI_ADRS_BIT-1 -: `USI_BLOCK_BIT] == `GPIO_BLOCK_ID;

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cmdRead  <= 1'b0;
			cmdWrite <= 1'b0;
		end
		else
		begin
			cmdRead  <= blockHit & ~susiWCke;
			cmdWrite <= blockHit & susiWCke;
		end
	end

	// Offset and data ride along with the strobes
	always_ff @(posedge sysClk)
	begin
		cmdOfs <= susiAdrs[`USI_ADRS_BIT-`USI_BLOCK_BIT-1:0];
		cmdWd  <= susiWd;
	end

	// --------------------
	// Registers and read
	// --------------------
	// Unimplemented offsets read as zero
	always_comb
	begin
		rdNext = '0;
		case (cmdOfs)
			ledEdgeOfs: rdNext[1:0]  = ledEdge;
			ledDivOfs:  rdNext[15:0] = ledDiv;
			default:    rdNext       = '0;
		endcase
	end

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			ledEdge <= 2'd0;
			ledDiv  <= 16'd0;
			susiVd  <= 1'b0;
		end
		else
		begin
			susiVd <= cmdRead;
			if (cmdWrite && cmdOfs == ledEdgeOfs)
			begin
				ledEdge <= cmdWd[1:0];
			end
			if (cmdWrite && cmdOfs == ledDivOfs)
			begin
				ledDiv <= cmdWd[15:0];
			end
		end
	end

	always_ff @(posedge sysClk)
	begin
		susiRd <= rdNext;
	end

	// --------------------
	// LED clock divider
	// --------------------
	// Toggle every ledDiv+1 cycles
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			divCnt <= 16'd0;
			ledClk <= 1'b0;
		end
		else if (divCnt >= ledDiv)
		begin
			// Also catches a divider lowered below the count
			divCnt <= 16'd0;
			ledClk <= ~ledClk;
		end
		else
		begin
			divCnt <= divCnt + 16'd1;
		end
	end

endmodule

// File: PwmBlock.sv
/*
 PWM slave on the register bus, drives the backlight control output.
 Offset 0 holds the period, offset 1 the duty, both 16 bits.
 Output is high for duty cycles out of every period+1.
*/
`timescale 1ns/1ns
`include "usiBus_settings.svh"

module PwmBlock
(
	input  logic            sysClk,
	input  logic            rstN,
	input  usiPkg::busDataT susiWd,
	input  usiPkg::busAdrsT susiAdrs,
	input  logic            susiWCke,
	output usiPkg::busDataT susiRd,
	output logic            susiVd,
	output logic            pwm
);

	localparam usiPkg::regOffsetT periodOfs = 'd0;
	localparam usiPkg::regOffsetT dutyOfs   = 'd1;

	// Decoded command stage
	logic              blockHit;
	logic              cmdRead;
	logic              cmdWrite;
	usiPkg::regOffsetT cmdOfs;
	usiPkg::busDataT   cmdWd;
	usiPkg::busDataT   rdNext;
	// PWM state
	logic [15:0]       period;
	logic [15:0]       duty;
	logic [15:0]       pwmCnt;

	// --------------------
	// Command decode
	// --------------------
	assign blockHit = susiAdrs[`USI_ADRS_BIT-1 -: `USI_BLOCK_BIT] == `PWM_BLOCK_ID;

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			cmdRead  <= 1'b0;
			cmdWrite <= 1'b0;
		end
		else
		begin
			cmdRead  <= blockHit & ~susiWCke;
			cmdWrite <= blockHit & susiWCke;
		end
	end

	always_ff @(posedge sysClk)
	begin
		cmdOfs <= susiAdrs[`USI_ADRS_BIT-`USI_BLOCK_BIT-1:0];
		cmdWd  <= susiWd;
	end

	// --------------------
	// Registers and read
	// --------------------
	always_comb
	begin
		rdNext = '0;
		case (cmdOfs)
			periodOfs: rdNext[15:0] = period;
			dutyOfs:   rdNext[15:0] = duty;
			default:   rdNext       = '0;
		endcase
	end

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			period <= 16'd0;
			duty   <= 16'd0;
			susiVd <= 1'b0;
		end
		else
		begin
			susiVd <= cmdRead;
			if (cmdWrite && cmdOfs == periodOfs)
			begin
				period <= cmdWd[15:0];
			end
			if (cmdWrite && cmdOfs == dutyOfs)
			begin
				duty <= cmdWd[15:0];
			end
		end
	end

	always_ff @(posedge sysClk)
	begin
		susiRd <= rdNext;
	end

	// --------------------
	// Counter and compare
	// --------------------
	// Counts 0..period then wraps, duty above period keeps pwm high
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			pwmCnt <= 16'd0;
			pwm    <= 1'b0;
		end
		else
		begin
			pwmCnt <= (pwmCnt >= period) ? 16'd0 : pwmCnt + 16'd1;
			pwm    <= pwmCnt < duty;
		end
	end

endmodule

// File: Processer.sv
/*
 Top level of the peripheral subsystem.
 The external master port feeds the bus interconnect, which serves the GPIO
 slave on lane 0 and the PWM backlight slave on lane 1.
*/
`timescale 1ns/1ns
`include "usiBus_settings.svh"

module Processer
(
	input  logic            sysClk,
	input  logic            rstN,
	// Master port
	input  usiPkg::busDataT musiWd,
	input  usiPkg::busAdrsT musiAdrs,
	input  logic            musiWCke,
	output usiPkg::busDataT musiRd,
	output usiPkg::busVdT   musiVd,
	// LED
	output logic [1:0]      ledEdge,
	output logic            ledClk,
	// Backlight
	output logic            backLightControl
);

	// Broadcast command to all slaves
	usiPkg::busDataT susiWd;
	usiPkg::busAdrsT susiAdrs;
	logic            susiWCke;
	// Per-slave answers
	usiPkg::busDataT gpioRd;
	logic            gpioVd;
	usiPkg::busDataT pwmRd;
	logic            pwmVd;

	// --------------------
	// Bus interconnect
	// --------------------
	// Lane order fixed, PWM upper and GPIO lower
	UltraSimpleInterface usiBus (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.musiWd   (musiWd),
		.musiAdrs (musiAdrs),
		.musiWCke (musiWCke),
		.musiRd   (musiRd),
		.musiVd   (musiVd),
		.susiWd   (susiWd),
		.susiAdrs (susiAdrs),
		.susiWCke (susiWCke),
		.susiRd   ({pwmRd, gpioRd}),
		.susiVd   ({pwmVd, gpioVd})
	);

	// --------------------
	// Slaves
	// --------------------
	GpioBlock gpioBlock (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.susiWd   (susiWd),
		.susiAdrs (susiAdrs),
		.susiWCke (susiWCke),
		.susiRd   (gpioRd),
		.susiVd   (gpioVd),
		.ledEdge  (ledEdge),
		.ledClk   (ledClk)
	);

	PwmBlock pwmBlock (
		.sysClk   (sysClk),
		.rstN     (rstN),
		.susiWd   (susiWd),
		.susiAdrs (susiAdrs),
		.susiWCke (susiWCke),
		.susiRd   (pwmRd),
		.susiVd   (pwmVd),
		.pwm      (backLightControl)
	);

endmodule

// File: processerChk.sv
/*
 Concurrent assertions on the read valid vector and the PWM output.
 Bound into the interconnect for the valid checks and into the PWM slave
 for the duty check. The checkBus parameter selects the set for a bind site.
 Ports that a bind site does not use are tied off there.
*/
`timescale 1ns/1ns

module processerChk
#(
	parameter bit checkBus = 1'b1
)
(
	input logic          sysClk,
	input logic          rstN,
	input usiPkg::busVdT vd,
	input logic          pwm,
	input logic [15:0]   duty
);

	// Count of failed assertions in this instance
	int failCnt = 0;

	if (checkBus)
	begin : busChecks
		// At most one slave answers per cycle
		validOneHot: assert property (@(posedge sysClk) disable iff (!rstN) $onehot0(vd))
		else
		begin
			$error("read valid vector %b is not one-hot", vd);
			failCnt++;
		end

		// No answer while in reset
		validInReset: assert property (@(posedge sysClk) !rstN |-> vd == '0)
		else
		begin
			$error("read valid vector %b set during reset", vd);
			failCnt++;
		end
	end
	else
	begin : pwmChecks
		// pwm lags duty by one register stage
		pwmDutyZero: assert property (@(posedge sysClk) disable iff (!rstN)
			(duty == 16'd0 && $past(duty) == 16'd0) |-> !pwm)
		else
		begin
			$error("pwm high while duty is zero");
			failCnt++;
		end
	end

endmodule

// --------------------
// Bind sites
// --------------------
bind UltraSimpleInterface processerChk #(.checkBus(1'b1)) busChk (
	.sysClk (sysClk),
	.rstN   (rstN),
	.vd     (musiVd),
	.pwm    (1'b0),
	.duty   (16'd0)
);

bind PwmBlock processerChk #(.checkBus(1'b0)) pwmChk (
	.sysClk (sysClk),
	.rstN   (rstN),
	.vd     ('0),
	.pwm    (pwm),
	.duty   (duty)
);

// File: tbProcesser.sv
/*
 Testbench for the peripheral subsystem top level.
 Issues register bus commands, predicts read answers from a shadow register
 model and measures the LED clock and PWM outputs. Six tests run in sequence.
*/
`timescale 1ns/1ns
`include "usiBus_settings.svh"

module tbProcesser;

	// Read in flight, tagged with the edge that samples it
	typedef struct packed {
		int              tag;
		usiPkg::busAdrsT adrs;
		usiPkg::busDataT data;
		usiPkg::busVdT   vd;
	} pendReadT;

	logic            sysClk;
	logic            rstN;
	usiPkg::busDataT musiWd;
	usiPkg::busAdrsT musiAdrs;
	logic            musiWCke;
	usiPkg::busDataT musiRd;
	usiPkg::busVdT   musiVd;
	logic [1:0]      ledEdge;
	logic            ledClk;
	logic            backLightControl;

	int          cycleCnt = 0;
	int          seed;
	int          cmpErrCnt = 0;
	int          chkErrCnt = 0;
	int          timeoutCnt = 0;
	int          testCnt = 0;
	int          testFailCnt = 0;
	bit          checkOn = 1'b0;
	// ledEdge, ledDiv, period, duty
	logic [15:0] shadow [4];
	pendReadT    pendQ [$];

	Processer DUT (
		.sysClk           (sysClk),
		.rstN             (rstN),
		.musiWd           (musiWd),
		.musiAdrs         (musiAdrs),
		.musiWCke         (musiWCke),
		.musiRd           (musiRd),
		.musiVd           (musiVd),
		.ledEdge          (ledEdge),
		.ledClk           (ledClk),
		.backLightControl (backLightControl)
	);

	initial
	begin
		sysClk = 1'b0;
		forever #5 sysClk = ~sysClk;
	end

	// Rising edge count
	initial
	begin
		forever
		begin
			@(posedge sysClk);
			cycleCnt++;
		end
	end

	// --------------------
	// Reference model
	// --------------------
	// Shadow slot of an implemented register, -1 otherwise
	function automatic int regIndex(input usiPkg::busAdrsT adrs);
		case (adrs[15:8])
			`GPIO_BLOCK_ID: regIndex = (adrs[7:0] < 8'd2) ? int'(adrs[0]) : -1;
			`PWM_BLOCK_ID:  regIndex = (adrs[7:0] < 8'd2) ? 2 + int'(adrs[0]) : -1;
			default:        regIndex = -1;
		endcase
	endfunction

	function automatic logic [15:0] widthMask(input int idx);
		widthMask = (idx == 0) ? 16'h0003 : 16'hFFFF;
	endfunction

	function automatic usiPkg::busAdrsT regAdrs(input int idx);
		case (idx)
			0:       regAdrs = {`GPIO_BLOCK_ID, 8'h00};
			1:       regAdrs = {`GPIO_BLOCK_ID, 8'h01};
			2:       regAdrs = {`PWM_BLOCK_ID, 8'h00};
			default: regAdrs = {`PWM_BLOCK_ID, 8'h01};
		endcase
	endfunction

	// Expected data and valid lanes for a read
	function automatic usiPkg::busDataT expectedRead(input usiPkg::busAdrsT adrs,
		output usiPkg::busVdT vd);
		int idx;
		idx = regIndex(adrs);
		expectedRead = '0;
		case (adrs[15:8])
			`GPIO_BLOCK_ID: vd = 2'b01;
			`PWM_BLOCK_ID:  vd = 2'b10;
			default:        vd = 2'b00;
		endcase
		// Unimplemented offsets of a mapped block read zero
		if (idx >= 0)
		begin
			expectedRead = {16'd0, shadow[idx]};
		end
	endfunction

	function automatic int minOf(input int a, input int b);
		minOf = (a < b) ? a : b;
	endfunction

	function automatic int errorTotal();
		errorTotal = cmpErrCnt + chkErrCnt
			+ DUT.usiBus.busChk.failCnt + DUT.pwmBlock.pwmChk.failCnt;
	endfunction

	// --------------------
	// Bus commands
	// --------------------
	// One command per cycle, just after the rising edge
	task automatic driveCmd(input usiPkg::busAdrsT adrs, input usiPkg::busDataT wd,
		input logic wCke);
		@(posedge sysClk);
		#1;
		musiAdrs = adrs;
		musiWd   = wd;
		musiWCke = wCke;
	endtask

	// Block 0 read, answered by nobody
	task automatic idleBus();
		driveCmd(16'h0000, '0, 1'b0);
	endtask

	task automatic writeReg(input usiPkg::busAdrsT adrs, input usiPkg::busDataT wd);
		int idx;
		driveCmd(adrs, wd, 1'b1);
		idx = regIndex(adrs);
		if (idx >= 0)
		begin
			shadow[idx] = wd[15:0] & widthMask(idx);
		end
	endtask

	task automatic readReg(input usiPkg::busAdrsT adrs);
		pendReadT      ent;
		usiPkg::busVdT vd;
		driveCmd(adrs, '0, 1'b0);
		ent.tag  = cycleCnt + 1;
		ent.adrs = adrs;
		ent.data = expectedRead(adrs, vd);
		ent.vd   = vd;
		pendQ.push_back(ent);
	endtask

	task automatic drainReads(output bit ok);
		int waitCnt;
		idleBus();
		waitCnt = 0;
		while (pendQ.size() != 0 && waitCnt < 20)
		begin
			@(posedge sysClk);
			waitCnt++;
		end
		ok = pendQ.size() == 0;
		if (!ok)
		begin
			$display("Timeout: %0d reads never came back", pendQ.size());
			timeoutCnt++;
		end
	endtask

	task automatic checkValue(input string name, input int got, input int want);
		assert (got == want)
		else
		begin
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, want);
			chkErrCnt++;
		end
	endtask

	// Falling edges until ledClk changes
	task automatic waitToggle(input int limit, output int cycles, output bit ok);
		logic prev;
		prev = ledClk;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < limit)
		begin
			@(negedge sysClk);
			cycles++;
			ok = ledClk !== prev;
		end
		if (!ok)
		begin
			$display("Timeout: ledClk did not toggle within %0d cycles", limit);
			timeoutCnt++;
		end
	endtask

	// --------------------
	// Read compare
	// --------------------
	// Answer due three edges after sampling, no valid otherwise
	initial
	begin
		pendReadT ent;
		forever
		begin
			@(negedge sysClk);
			if (checkOn && pendQ.size() != 0 && pendQ[0].tag + 3 == cycleCnt)
			begin
				ent = pendQ.pop_front();
				assert (musiVd === ent.vd)
				else
				begin
					$display("Error at %0t: musiVd is %b, expected %b (address 0x%h)",
						$time, musiVd, ent.vd, ent.adrs);
					cmpErrCnt++;
				end
				if (ent.vd != '0)
				begin
					assert (musiRd === ent.data)
					else
					begin
						$display("Error at %0t: musiRd is 0x%h, expected 0x%h (address 0x%h)",
							$time, musiRd, ent.data, ent.adrs);
						cmpErrCnt++;
					end
				end
			end
			else if (checkOn)
			begin
				assert (musiVd === '0)
				else
				begin
					$display("Error at %0t: musiVd is %b, expected 00", $time, musiVd);
					cmpErrCnt++;
				end
			end
		end
	end

	// --------------------
	// Tests
	// --------------------
	task automatic testResetState();
		bit ok;
		repeat (8) @(posedge sysClk);
		#1;
		checkValue("ledEdge", int'(ledEdge), 0);
		checkValue("ledClk", int'(ledClk), 0);
		checkValue("backLightControl", int'(backLightControl), 0);
		rstN = 1'b1;
		checkOn = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			readReg(regAdrs(i));
		end
		drainReads(ok);
	endtask

	task automatic testWriteRead();
		bit ok;
		for (int rep = 0; rep < 3; rep++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				writeReg(regAdrs(i), $random(seed));
			end
			for (int i = 0; i < 4; i++)
			begin
				readReg(regAdrs(i));
			end
			drainReads(ok);
			if (!ok)
			begin
				return;
			end
		end
	endtask

	// GPIO and PWM in turn, one read per cycle
	task automatic testPipelined();
		bit ok;
		for (int i = 0; i < 16; i++)
		begin
			readReg(regAdrs((i % 2) * 2 + (i / 2) % 2));
		end
		drainReads(ok);
	endtask

	task automatic testUnmapped();
		bit ok;
		readReg({8'h00, 8'h00});
		readReg({8'h03, 8'h01});
		readReg({8'h07, 8'h00});
		readReg({8'hFF, 8'h02});
		readReg({`GPIO_BLOCK_ID, 8'h02});
		readReg({`GPIO_BLOCK_ID, 8'hFF});
		readReg({`PWM_BLOCK_ID, 8'h05});
		writeReg({8'h00, 8'h00}, $random(seed));
		writeReg({8'h03, 8'h00}, $random(seed));
		writeReg({8'h03, 8'h01}, $random(seed));
		writeReg({`GPIO_BLOCK_ID, 8'h02}, $random(seed));
		writeReg({`PWM_BLOCK_ID, 8'h10}, $random(seed));
		for (int i = 0; i < 4; i++)
		begin
			readReg(regAdrs(i));
		end
		drainReads(ok);
	endtask

	task automatic testPwmDuty();
		int periodTab [5] = '{9, 4, 5, 7, 0};
		int dutyTab [5] = '{3, 0, 9, 8, 1};
		int highCnt;
		for (int k = 0; k < 5; k++)
		begin
			writeReg(regAdrs(2), periodTab[k]);
			writeReg(regAdrs(3), dutyTab[k]);
			idleBus();
			// Registers, counter wrap and output stage settle
			repeat (6) @(posedge sysClk);
			highCnt = 0;
			for (int c = 0; c <= periodTab[k]; c++)
			begin
				@(negedge sysClk);
				highCnt += int'(backLightControl);
			end
			checkValue("backLightControl high cycles", highCnt,
				minOf(dutyTab[k], periodTab[k] + 1));
		end
	endtask

	task automatic testLedClock();
		int divTab [4] = '{0, 3, 7, 12};
		int gap;
		bit ok;
		for (int k = 0; k < 4; k++)
		begin
			writeReg(regAdrs(1), divTab[k]);
			writeReg(regAdrs(0), $random(seed));
			idleBus();
			repeat (4) @(posedge sysClk);
			@(negedge sysClk);
			checkValue("ledEdge", int'(ledEdge), int'(shadow[0]));
			// First interval may be partial
			waitToggle(divTab[k] + 10, gap, ok);
			for (int n = 0; n < 3 && ok; n++)
			begin
				waitToggle(divTab[k] + 10, gap, ok);
				checkValue("ledClk toggle interval", gap, divTab[k] + 1);
			end
			if (!ok)
			begin
				return;
			end
		end
	endtask

	task automatic runTest(input int t);
		int    errBefore;
		string name;
		errBefore = errorTotal();
		case (t)
			1:       name = "reset state";
			2:       name = "write and read back";
			3:       name = "pipelined reads";
			4:       name = "unmapped addresses";
			5:       name = "PWM duty";
			default: name = "LED clock";
		endcase
		case (t)
			1:       testResetState();
			2:       testWriteRead();
			3:       testPipelined();
			4:       testUnmapped();
			5:       testPwmDuty();
			default: testLedClock();
		endcase
		testCnt++;
		if (errorTotal() != errBefore || timeoutCnt != 0)
		begin
			testFailCnt++;
			$display("Test %0d %s: failed", t, name);
		end
		else
		begin
			$display("Test %0d %s: ok", t, name);
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		seed     = 88;
		rstN     = 1'b0;
		musiWd   = '0;
		musiAdrs = '0;
		musiWCke = 1'b0;
		for (int i = 0; i < 4; i++)
		begin
			shadow[i] = 16'd0;
		end
		// Stop after the first test that times out
		for (int t = 1; t <= 6; t++)
		begin
			if (timeoutCnt == 0)
			begin
				runTest(t);
			end
		end
		$display("Tests run %0d, failed %0d, check errors %0d, timeouts %0d",
			testCnt, testFailCnt, errorTotal(), timeoutCnt);
		if (errorTotal() == 0 && timeoutCnt == 0 && testFailCnt == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+.
usiPkg.sv
UltraSimpleInterface.sv
GpioBlock.sv
PwmBlock.sv
Processer.sv
processerChk.sv
tbProcesser.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and report the result as exit status
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tbProcesser -Mdir obj_dir -o simProcesser -f list.f || exit 1

# Assertion errors must not stop the run before the closing report
out=$(./obj_dir/simProcesser +verilator+error+limit+1000)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1
